// File: hw/ctrl_pkg.sv
/*
 * decode control package
 * opcodes, operation encodings, selectors and the control words
 * shared by the instruction-decode block
 */

package ctrl_pkg;

	////////////////////////////////////////
	// widths and fixed values
	////////////////////////////////////////
	localparam int insn_w     = 32;
	localparam int reg_addr_w = 5;

	// jump-and-link writes here
	localparam logic [reg_addr_w-1:0] link_reg = 5'd9;

	// pipeline filler, nop with bit 16 set
	localparam logic [insn_w-1:0] nop_insn = {6'h05, 26'h041_0000};

	// rotate-right sub-op of shrot, bits 9:6
	localparam logic [3:0] shrot_ror = 4'd3;

	////////////////////////////////////////
	// major opcodes, bits 31:26
	////////////////////////////////////////
	typedef enum logic [5:0] {
		op_j       = 6'h00, op_jal   = 6'h01, op_bnf    = 6'h03, op_bf    = 6'h04,
		op_nop     = 6'h05, op_movhi = 6'h06, op_xsync  = 6'h08, op_rfe   = 6'h09,
		op_jr      = 6'h11, op_jalr  = 6'h12, op_lwz    = 6'h21, op_lws   = 6'h22,
		op_lbz     = 6'h23, op_lbs   = 6'h24, op_lhz    = 6'h25, op_lhs   = 6'h26,
		op_addi    = 6'h27, op_addic = 6'h28, op_andi   = 6'h29, op_ori   = 6'h2a,
		op_xori    = 6'h2b, op_mfspr = 6'h2d, op_sh_roti = 6'h2e, op_sfxxi = 6'h2f,
		op_mtspr   = 6'h30, op_sw    = 6'h35, op_sb     = 6'h36, op_sh    = 6'h37,
		op_alu     = 6'h38, op_sfxx  = 6'h39
	} opcode_e;

	// low values match register-form alu bits 4:0
	typedef enum logic [4:0] {
		alu_add   = 5'd0,  alu_addc = 5'd1,  alu_sub  = 5'd2,  alu_and  = 5'd3,
		alu_or    = 5'd4,  alu_xor  = 5'd5,  alu_mul  = 5'd6,  alu_shrot = 5'd8,
		alu_div   = 5'd9,  alu_divu = 5'd10, alu_mulu = 5'd11, alu_ffl1 = 5'd15,
		alu_movhi = 5'd16, alu_comp = 5'd17, alu_nop  = 5'd31
	} alu_op_e;

	typedef enum logic [2:0] {
		br_nop = 3'd0, br_j = 3'd1, br_jr = 3'd2, br_bf = 3'd4, br_bnf = 3'd5, br_rfe = 3'd6
	} branch_op_e;

	// bit 3 marks a store
	typedef enum logic [3:0] {
		lsu_nop = 4'b0000, lsu_lbz = 4'b0010, lsu_lbs = 4'b0011, lsu_lhz = 4'b0100,
		lsu_lhs = 4'b0101, lsu_lwz = 4'b0110, lsu_lws = 4'b0111, lsu_sb  = 4'b1010,
		lsu_sh  = 4'b1100, lsu_sw  = 4'b1110
	} lsu_op_e;

	typedef enum logic [1:0] {
		wb_alu = 2'd0, wb_lsu = 2'd1, wb_sprs = 2'd2, wb_lr = 2'd3
	} wb_src_e;

	typedef enum logic [1:0] {
		sel_src_rf = 2'd0, sel_src_imm = 2'd1, sel_src_ex_forw = 2'd2, sel_src_wb_forw = 2'd3
	} sel_e;

	////////////////////////////////////////
	// control words
	////////////////////////////////////////
	// write enable sits in bit 0
	typedef struct packed {
		wb_src_e src;
		logic    we;
	} rfwb_op_t;

	typedef struct packed {
		logic id_load;
		logic id_clear;
		logic ex_load;
		logic ex_clear;
		logic wb_load;
	} stage_en_t;

	typedef struct packed {
		alu_op_e                 alu_op;
		logic [3:0]              comp_op;
		rfwb_op_t                rfwb_op;
		logic [reg_addr_w-1:0]   rf_addrw;
		logic [insn_w-1:0]       simm;
		branch_op_e              branch_op;
		logic                    illegal;
		logic                    syscall;
		logic                    trap;
	} ex_ctrl_t;

	// bubble and reset value of the EX word
	localparam ex_ctrl_t ex_ctrl_idle = '{
		alu_op: alu_nop, comp_op: 4'd0, rfwb_op: '{src: wb_alu, we: 1'b0},
		rf_addrw: '0, simm: '0, branch_op: br_nop,
		illegal: 1'b0, syscall: 1'b0, trap: 1'b0
	};

endpackage

// File: hw/insn_pipe.sv
/*
 * instruction latches for the ID, EX and WB stages
 * also decides stage load and clear for the whole decode block
 */

`timescale 1ns/10ps

module insn_pipe (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [ctrl_pkg::insn_w-1:0] if_insn,
	input  logic                        id_freeze,
	input  logic                        ex_freeze,
	input  logic                        wb_freeze,
	input  logic                        flush,
	output ctrl_pkg::stage_en_t         stage_en,
	output logic [ctrl_pkg::insn_w-1:0] id_insn,
	output logic [ctrl_pkg::insn_w-1:0] ex_insn,
	output logic [ctrl_pkg::insn_w-1:0] wb_insn
);
	import ctrl_pkg::*;

	////////////////////////////////////////
	// stage actions
	////////////////////////////////////////
	always_comb begin
		// flush beats the ID load
		stage_en.id_clear = flush;
		stage_en.id_load  = !id_freeze && !flush;
		// bubble when EX moves on but ID is held
		stage_en.ex_clear = flush || (!ex_freeze && id_freeze);
		stage_en.ex_load  = !ex_freeze && !stage_en.ex_clear;
		// WB keeps going through a flush
		stage_en.wb_load  = !wb_freeze;
	end

	////////////////////////////////////////
	// latches
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset || stage_en.id_clear) begin
			id_insn <= nop_insn;
		end else if (stage_en.id_load) begin
			id_insn <= if_insn;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || stage_en.ex_clear) begin
			ex_insn <= nop_insn;
		end else if (stage_en.ex_load) begin
			ex_insn <= id_insn;
		end
	end

	// frozen WB holds its insn
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_insn <= nop_insn;
		end else if (stage_en.wb_load) begin
			wb_insn <= ex_insn;
		end
	end

endmodule

// File: hw/fetch_decode.sv
/*
 * fetch-time decode
 * branch op and immediate select, registered with id_insn
 */

`timescale 1ns/10ps

module fetch_decode (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [ctrl_pkg::insn_w-1:0] if_insn,
	input  ctrl_pkg::stage_en_t         stage_en,
	output ctrl_pkg::branch_op_e        id_branch_op,
	output logic                        sel_imm
);
	import ctrl_pkg::*;

	opcode_e    if_op;
	branch_op_e branch_next;
	logic       imm_next;

	assign if_op = opcode_e'(if_insn[31:26]);

	always_comb begin
		case (if_op)
			op_j, op_jal:   branch_next = br_j;
			op_jr, op_jalr: branch_next = br_jr;
			op_bnf:         branch_next = br_bnf;
			op_bf:          branch_next = br_bf;
			op_rfe:         branch_next = br_rfe;
			default:        branch_next = br_nop;
		endcase
	end

	// register forms take operand B from the regfile
	always_comb begin
		case (if_op)
			op_jalr, op_jr, op_rfe, op_mfspr, op_mtspr, op_xsync,
			op_sw, op_sb, op_sh, op_alu, op_sfxx, op_nop:
				imm_next = 1'b0;
			default:
				imm_next = 1'b1;
		endcase
	end

	// cleared ID looks like the filler nop
	always_ff @(posedge clk) begin
		if (reset || stage_en.id_clear) begin
			id_branch_op <= br_nop;
			sel_imm      <= 1'b0;
		end else if (stage_en.id_load) begin
			id_branch_op <= branch_next;
			sel_imm      <= imm_next;
		end
	end

endmodule

// File: hw/exec_decode.sv
/*
 * ID-stage decode and registered EX control word
 * immediates, load/store op, alu and write-back ops,
 * illegal insn, syscall and trap
 */

`timescale 1ns/10ps

module exec_decode (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [ctrl_pkg::insn_w-1:0] id_insn,
	input  ctrl_pkg::branch_op_e        id_branch_op,
	input  ctrl_pkg::stage_en_t         stage_en,
	input  logic                        du_hwbkpt,
	output logic [ctrl_pkg::insn_w-1:0] id_simm,
	output ctrl_pkg::lsu_op_e           id_lsu_op,
	output ctrl_pkg::ex_ctrl_t          ex_ctrl
);
	import ctrl_pkg::*;

	opcode_e  id_op;
	ex_ctrl_t ex_next;
	logic     alu_bad;

	assign id_op = opcode_e'(id_insn[31:26]);

	////////////////////////////////////////
	// ID stage, combinational
	////////////////////////////////////////
	always_comb begin
		case (id_op)
			op_addi, op_addic, op_xori, op_sfxxi,
			op_lwz, op_lws, op_lbz, op_lbs, op_lhz, op_lhs:
				id_simm = {{16{id_insn[15]}}, id_insn[15:0]};
			// spr number split across two fields
			op_mtspr:
				id_simm = {16'b0, id_insn[25:21], id_insn[10:0]};
			// store offset, same split but signed
			op_sw, op_sh, op_sb:
				id_simm = {{16{id_insn[25]}}, id_insn[25:21], id_insn[10:0]};
			default:
				id_simm = {16'b0, id_insn[15:0]};
		endcase
	end

	always_comb begin
		case (id_op)
			op_lwz:  id_lsu_op = lsu_lwz;
			op_lws:  id_lsu_op = lsu_lws;
			op_lbz:  id_lsu_op = lsu_lbz;
			op_lbs:  id_lsu_op = lsu_lbs;
			op_lhz:  id_lsu_op = lsu_lhz;
			op_lhs:  id_lsu_op = lsu_lhs;
			op_sw:   id_lsu_op = lsu_sw;
			op_sb:   id_lsu_op = lsu_sb;
			op_sh:   id_lsu_op = lsu_sh;
			default: id_lsu_op = lsu_nop;
		endcase
	end

	// no multiplier, divider, carry add, ffl1 or rotate here
	assign alu_bad = (id_insn[4:0] == alu_addc) || (id_insn[4:0] == alu_ffl1) ||
		(id_insn[4:0] == alu_div) || (id_insn[4:0] == alu_divu) ||
		(id_insn[4:0] == alu_mul) || (id_insn[4:0] == alu_mulu) ||
		((id_insn[4:0] == alu_shrot) && (id_insn[9:6] == shrot_ror));

	////////////////////////////////////////
	// next EX control word
	////////////////////////////////////////
	always_comb begin
		ex_next           = ex_ctrl_idle;
		ex_next.comp_op   = id_insn[24:21];
		ex_next.simm      = id_simm;
		ex_next.branch_op = id_branch_op;
		ex_next.rf_addrw  = id_insn[25:21];
		ex_next.syscall   = (id_op == op_xsync) && (id_insn[25:23] == 3'b000);
		ex_next.trap      = ((id_op == op_xsync) && (id_insn[25:23] == 3'b010)) || du_hwbkpt;
		case (id_op)
			op_jal, op_jalr: begin
				ex_next.rfwb_op  = '{src: wb_lr, we: 1'b1};
				ex_next.rf_addrw = link_reg;
			end
			op_movhi: begin
				ex_next.alu_op  = alu_movhi;
				ex_next.rfwb_op = '{src: wb_alu, we: 1'b1};
			end
			op_mfspr:
				ex_next.rfwb_op = '{src: wb_sprs, we: 1'b1};
			op_lwz, op_lws, op_lbz, op_lbs, op_lhz, op_lhs:
				ex_next.rfwb_op = '{src: wb_lsu, we: 1'b1};
			op_addi, op_addic, op_andi, op_ori, op_xori, op_sh_roti: begin
				ex_next.rfwb_op = '{src: wb_alu, we: 1'b1};
				case (id_op)
					op_addi:  ex_next.alu_op = alu_add;
					op_addic: ex_next.alu_op = alu_addc;
					op_andi:  ex_next.alu_op = alu_and;
					op_ori:   ex_next.alu_op = alu_or;
					op_xori:  ex_next.alu_op = alu_xor;
					default:  ex_next.alu_op = alu_shrot;
				endcase
			end
			// register-form alu op from the low field
			op_alu: begin
				ex_next.alu_op  = alu_op_e'({1'b0, id_insn[3:0]});
				ex_next.rfwb_op = '{src: wb_alu, we: 1'b1};
				ex_next.illegal = alu_bad;
			end
			op_sfxx, op_sfxxi:
				ex_next.alu_op = alu_comp;
			// legal, nothing to write back
			op_j, op_bnf, op_bf, op_jr, op_rfe, op_xsync, op_mtspr,
			op_sw, op_sb, op_sh, op_nop: ;
			default:
				ex_next.illegal = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset || stage_en.ex_clear) begin
			ex_ctrl <= ex_ctrl_idle;
		end else if (stage_en.ex_load) begin
			ex_ctrl <= ex_next;
		end
	end

endmodule

// File: hw/operand_select.sv
/*
 * operand forwarding select
 * picks regfile, immediate or a forwarded result for A and B
 */

`timescale 1ns/10ps

module operand_select (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [ctrl_pkg::insn_w-1:0] id_insn,
	input  logic                        sel_imm,
	input  ctrl_pkg::ex_ctrl_t          ex_ctrl,
	input  ctrl_pkg::stage_en_t         stage_en,
	input  logic                        wbforw_valid,
	output ctrl_pkg::sel_e              sel_a,
	output ctrl_pkg::sel_e              sel_b
);
	import ctrl_pkg::*;

	logic [reg_addr_w-1:0] wb_rf_addrw;

	// write address one stage behind EX
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_rf_addrw <= '0;
		end else if (stage_en.wb_load) begin
			wb_rf_addrw <= ex_ctrl.rf_addrw;
		end
	end

	// EX result wins over WB
	function automatic sel_e fwd_sel(input logic [reg_addr_w-1:0] src);
		if ((src == ex_ctrl.rf_addrw) && ex_ctrl.rfwb_op.we)
			return sel_src_ex_forw;
		else if ((src == wb_rf_addrw) && wbforw_valid)
			return sel_src_wb_forw;
		else
			return sel_src_rf;
	endfunction

	assign sel_a = fwd_sel(id_insn[20:16]);
	assign sel_b = sel_imm ? sel_src_imm : fwd_sel(id_insn[15:11]);

endmodule

// File: hw/ctrl_top.sv
/*
 * instruction-decode control, top level
 * latches, fetch decode, EX decode and forwarding select
 */

`timescale 1ns/10ps

module ctrl_top (
	input  logic                                clk,
	input  logic                                reset,
	input  logic [ctrl_pkg::insn_w-1:0]         if_insn,
	input  logic                                id_freeze,
	input  logic                                ex_freeze,
	input  logic                                wb_freeze,
	input  logic                                flush,
	input  logic                                wbforw_valid,
	input  logic                                du_hwbkpt,
	output logic [ctrl_pkg::insn_w-1:0]         id_insn,
	output logic [ctrl_pkg::insn_w-1:0]         ex_insn,
	output logic [ctrl_pkg::insn_w-1:0]         wb_insn,
	output logic [ctrl_pkg::reg_addr_w-1:0]     rf_addra,
	output logic [ctrl_pkg::reg_addr_w-1:0]     rf_addrb,
	output ctrl_pkg::branch_op_e                id_branch_op,
	output ctrl_pkg::lsu_op_e                   id_lsu_op,
	output logic [ctrl_pkg::insn_w-1:0]         id_simm,
	output ctrl_pkg::ex_ctrl_t                  ex_ctrl,
	output ctrl_pkg::sel_e                      sel_a,
	output ctrl_pkg::sel_e                      sel_b
);
	import ctrl_pkg::*;

	stage_en_t stage_en;
	logic      sel_imm;

	// regfile reads start straight from the fetched insn
	assign rf_addra = if_insn[20:16];
	assign rf_addrb = if_insn[15:11];

	////////////////////////////////////////
	// stages
	////////////////////////////////////////
	insn_pipe u_pipe (
		.clk(clk), .reset(reset), .if_insn(if_insn),
		.id_freeze(id_freeze), .ex_freeze(ex_freeze), .wb_freeze(wb_freeze),
		.flush(flush), .stage_en(stage_en),
		.id_insn(id_insn), .ex_insn(ex_insn), .wb_insn(wb_insn)
	);

	fetch_decode u_fetch (
		.clk(clk), .reset(reset), .if_insn(if_insn), .stage_en(stage_en),
		.id_branch_op(id_branch_op), .sel_imm(sel_imm)
	);

	exec_decode u_exec (
		.clk(clk), .reset(reset), .id_insn(id_insn), .id_branch_op(id_branch_op),
		.stage_en(stage_en), .du_hwbkpt(du_hwbkpt),
		.id_simm(id_simm), .id_lsu_op(id_lsu_op), .ex_ctrl(ex_ctrl)
	);

	// forwarding sees the live EX word
	operand_select u_opsel (
		.clk(clk), .reset(reset), .id_insn(id_insn), .sel_imm(sel_imm),
		.ex_ctrl(ex_ctrl), .stage_en(stage_en), .wbforw_valid(wbforw_valid),
		.sel_a(sel_a), .sel_b(sel_b)
	);

endmodule

// File: test/ctrl_properties.sv
/*
 * pipeline latch properties, bound into insn_pipe
 * flush and EX clear leave the filler nop, held stages keep their insn
 */

`timescale 1ns/10ps

module ctrl_properties (
	input logic                        clk,
	input logic                        reset,
	input logic                        flush,
	input ctrl_pkg::stage_en_t         stage_en,
	input logic [ctrl_pkg::insn_w-1:0] id_insn,
	input logic [ctrl_pkg::insn_w-1:0] ex_insn,
	input logic [ctrl_pkg::insn_w-1:0] wb_insn
);
	import ctrl_pkg::*;

	// flushed ID holds the filler
	flush_empties_id: assert property (@(posedge clk) disable iff (reset)
		flush |=> id_insn == nop_insn)
		else $error("id_insn is not the filler nop after a flush");

	// bubble or flush in EX
	clear_empties_ex: assert property (@(posedge clk) disable iff (reset)
		stage_en.ex_clear |=> ex_insn == nop_insn)
		else $error("ex_insn is not the filler nop after an EX clear");

	// neither load nor clear, ID keeps its insn
	id_hold: assert property (@(posedge clk) disable iff (reset)
		!stage_en.id_load && !stage_en.id_clear |=> $stable(id_insn))
		else $error("id_insn changed while ID was held");

	// frozen WB keeps its insn, flush or not
	wb_hold: assert property (@(posedge clk) disable iff (reset)
		!stage_en.wb_load |=> $stable(wb_insn))
		else $error("wb_insn changed while WB was frozen");

endmodule

bind insn_pipe ctrl_properties props0 (
	.clk(clk), .reset(reset), .flush(flush), .stage_en(stage_en),
	.id_insn(id_insn), .ex_insn(ex_insn), .wb_insn(wb_insn)
);

// File: test/ctrl_tb.sv
/*
 * testbench for the decode control block
 * plays golden vectors cycle by cycle and compares every output
 */

`timescale 1ns/10ps

module ctrl_tb;
	import ctrl_pkg::*;

	localparam int n_vec     = 23;
	localparam int vec_words = 9;

	logic                  clk;
	logic                  reset;
	logic [insn_w-1:0]     if_insn;
	logic                  id_freeze;
	logic                  ex_freeze;
	logic                  wb_freeze;
	logic                  flush;
	logic                  wbforw_valid;
	logic                  du_hwbkpt;
	logic [insn_w-1:0]     id_insn;
	logic [insn_w-1:0]     ex_insn;
	logic [insn_w-1:0]     wb_insn;
	logic [reg_addr_w-1:0] rf_addra;
	logic [reg_addr_w-1:0] rf_addrb;
	branch_op_e            id_branch_op;
	lsu_op_e               id_lsu_op;
	logic [insn_w-1:0]     id_simm;
	ex_ctrl_t              ex_ctrl;
	sel_e                  sel_a;
	sel_e                  sel_b;

	logic [31:0] golden [0:n_vec*vec_words-1];
	int          vec_errors;
	int          n_pass;
	int          n_fail;

	ctrl_top dut0 (
		.clk(clk), .reset(reset), .if_insn(if_insn),
		.id_freeze(id_freeze), .ex_freeze(ex_freeze), .wb_freeze(wb_freeze),
		.flush(flush), .wbforw_valid(wbforw_valid), .du_hwbkpt(du_hwbkpt),
		.id_insn(id_insn), .ex_insn(ex_insn), .wb_insn(wb_insn),
		.rf_addra(rf_addra), .rf_addrb(rf_addrb), .id_branch_op(id_branch_op),
		.id_lsu_op(id_lsu_op), .id_simm(id_simm), .ex_ctrl(ex_ctrl),
		.sel_a(sel_a), .sel_b(sel_b)
	);

	// 100 ns period
	always #50 clk = ~clk;

	////////////////////////////////////////
	// compare helpers
	////////////////////////////////////////
	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
		vec_errors++;
	endtask

	task automatic compare_insn(input string name, input logic [insn_w-1:0] got,
			input logic [insn_w-1:0] exp);
		if (got !== exp)
			report_mismatch(name, got, exp);
	endtask

	task automatic compare_addr(input string name, input logic [reg_addr_w-1:0] got,
			input logic [reg_addr_w-1:0] exp);
		if (got !== exp)
			report_mismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic compare_branch(input string name, input branch_op_e got,
			input branch_op_e exp);
		if (got !== exp)
			report_mismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic compare_lsu(input string name, input lsu_op_e got, input lsu_op_e exp);
		if (got !== exp)
			report_mismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic compare_sel(input string name, input sel_e got, input sel_e exp);
		if (got !== exp)
			report_mismatch(name, 32'(got), 32'(exp));
	endtask

	// field by field, so the line names the culprit
	task automatic compare_ex_ctrl(input ex_ctrl_t got, input ex_ctrl_t exp);
		if (got.alu_op !== exp.alu_op)
			report_mismatch("ex_ctrl.alu_op", 32'(got.alu_op), 32'(exp.alu_op));
		if (got.comp_op !== exp.comp_op)
			report_mismatch("ex_ctrl.comp_op", 32'(got.comp_op), 32'(exp.comp_op));
		if (got.rfwb_op !== exp.rfwb_op)
			report_mismatch("ex_ctrl.rfwb_op", 32'(got.rfwb_op), 32'(exp.rfwb_op));
		if (got.rf_addrw !== exp.rf_addrw)
			report_mismatch("ex_ctrl.rf_addrw", 32'(got.rf_addrw), 32'(exp.rf_addrw));
		if (got.simm !== exp.simm)
			report_mismatch("ex_ctrl.simm", got.simm, exp.simm);
		compare_branch("ex_ctrl.branch_op", got.branch_op, exp.branch_op);
		if ({got.illegal, got.syscall, got.trap} !== {exp.illegal, exp.syscall, exp.trap})
			report_mismatch("ex_ctrl.illegal/syscall/trap",
				32'({got.illegal, got.syscall, got.trap}),
				32'({exp.illegal, exp.syscall, exp.trap}));
	endtask

	////////////////////////////////////////
	// golden vector access
	////////////////////////////////////////
	// packed EX word column plus its simm column
	function automatic ex_ctrl_t unpack_ex_ctrl(input logic [31:0] h, input logic [31:0] simm);
		ex_ctrl_t e;
		e.alu_op    = alu_op_e'(h[28:24]);
		e.comp_op   = h[23:20];
		e.rfwb_op   = rfwb_op_t'(h[18:16]);
		e.rf_addrw  = h[12:8];
		e.simm      = simm;
		e.branch_op = branch_op_e'(h[6:4]);
		e.illegal   = h[2];
		e.syscall   = h[1];
		e.trap      = h[0];
		return e;
	endfunction

	task automatic drive_vector(input int v);
		logic [31:0] c;
		c            = golden[v*vec_words];
		id_freeze    = c[5];
		ex_freeze    = c[4];
		wb_freeze    = c[3];
		flush        = c[2];
		wbforw_valid = c[1];
		du_hwbkpt    = c[0];
		if_insn      = golden[v*vec_words+1];
	endtask

	task automatic check_vector(input int v);
		int          b;
		logic [31:0] g;
		logic [31:0] f;
		b          = v * vec_words;
		g          = golden[b+6];
		f          = golden[b+1];
		vec_errors = 0;
		// regfile read addresses come straight from the fetched insn
		compare_addr("rf_addra", rf_addra, f[20:16]);
		compare_addr("rf_addrb", rf_addrb, f[15:11]);
		compare_insn("id_insn", id_insn, golden[b+2]);
		compare_insn("ex_insn", ex_insn, golden[b+3]);
		compare_insn("wb_insn", wb_insn, golden[b+4]);
		compare_insn("id_simm", id_simm, golden[b+5]);
		compare_lsu("id_lsu_op", id_lsu_op, lsu_op_e'(g[15:12]));
		compare_branch("id_branch_op", id_branch_op, branch_op_e'(g[10:8]));
		compare_sel("sel_a", sel_a, sel_e'(g[5:4]));
		compare_sel("sel_b", sel_b, sel_e'(g[1:0]));
		compare_ex_ctrl(ex_ctrl, unpack_ex_ctrl(golden[b+7], golden[b+8]));
		if (vec_errors == 0) begin
			n_pass++;
			$display("vector %0d: pass", v);
		end else begin
			n_fail++;
			$display("vector %0d: %0d mismatches", v, vec_errors);
		end
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////
	initial begin
		void'($urandom(627));
		clk          = 1'b0;
		reset        = 1'b1;
		if_insn      = nop_insn;
		id_freeze    = 1'b0;
		ex_freeze    = 1'b0;
		wb_freeze    = 1'b0;
		flush        = 1'b0;
		wbforw_valid = 1'b0;
		du_hwbkpt    = 1'b0;
		n_pass       = 0;
		n_fail       = 0;
		$readmemh("test/ctrl_golden.txt", golden);
		// reset overrides the stage controls, so freezes may wander
		repeat (7) begin
			@(negedge clk);
			id_freeze = 1'($urandom);
			ex_freeze = 1'($urandom);
			wb_freeze = 1'($urandom);
		end
		@(negedge clk);
		reset = 1'b0;
		// drive on the falling edge, check 10 ns before the next one
		for (int v = 0; v < n_vec; v++) begin
			if (v > 0)
				@(negedge clk);
			drive_vector(v);
			@(posedge clk);
			#40;
			check_vector(v);
		end
		$display("vectors: %0d passed, %0d failed", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// golden length plus margin
	initial begin
		#((n_vec + 20) * 100);
		$display("timeout: golden playback did not finish within %0d cycles", n_vec + 20);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: or1k_ctrl.f
hw/ctrl_pkg.sv
hw/insn_pipe.sv
hw/fetch_decode.sv
hw/exec_decode.sv
hw/operand_select.sv
hw/ctrl_top.sv
test/ctrl_properties.sv
test/ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the decode control testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f or1k_ctrl.f --top-module ctrl_tb -o ctrl_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/ctrl_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the testbench prints the pass line only when every vector matched
if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
exit 1

// File: test/ctrl_golden.txt
// ctl if_insn id_insn ex_insn wb_insn id_simm {lsu,br,sel_a,sel_b} {alu,cmp,wb,rfw,br,flg} ex_simm
// ctl bits 5 id_frz, 4 ex_frz, 3 wb_frz, 2 flush, 1 wbforw_valid, 0 du_hwbkpt; flg {ill,sys,trap}
00 9c618004 9c618004 14410000 14410000 ffff8004 0001 1f200200 00000000
00 e0831000 e0831000 9c618004 14410000 00001000 0020 00310300 ffff8004
00 84a40010 84a40010 e0831000 9c618004 00000010 6021 00410400 00001000
02 04000100 04000100 84a40010 e0831000 00000100 0101 1f530500 00000010
02 e4042800 e4042800 04000100 84a40010 00002800 0003 1f070910 00000100
00 a8c08001 a8c08001 e4042800 04000100 00008001 0001 11000000 00002800
00 c3e61805 c3e61805 a8c08001 e4042800 0000f805 0020 04610600 00008001
00 d6013004 d6013004 c3e61805 a8c08001 ffff8004 e000 1ff01f00 0000f805
00 9ce61234 9ce61234 d6013004 c3e61805 00001234 0001 1f001000 ffff8004
00 fc000000 fc000000 9ce61234 d6013004 00000000 0001 00710700 00001234
00 e1011006 e1011006 fc000000 9ce61234 00001006 0000 1f000004 00000000
00 20000001 20000001 e1011006 fc000000 00000001 0000 06810804 00001006
00 21000002 21000002 20000001 e1011006 00000002 0000 1f000002 00000001
00 14410000 14410000 21000002 20000001 00000000 0000 1f800801 00000002
01 00000040 00000040 14410000 21000002 00000040 0101 1f200201 00000000
00 48002800 48002800 00000040 14410000 00002800 0200 1f000010 00000040
00 10000010 10000010 48002800 00000040 00000010 0401 1f070920 00002800
00 24000000 24000000 10000010 48002800 00000000 0600 1f000040 00000010
20 9c618004 24000000 14410000 10000010 00000000 0600 1f000000 00000000
00 e0831000 e0831000 24000000 14410000 00001000 0000 1f000060 00000000
00 84a40010 84a40010 e0831000 24000000 00000010 6021 00410400 00001000
0c 04000100 14410000 14410000 24000000 00000000 0000 1f000000 00000000
00 e4042800 e4042800 14410000 14410000 00002800 0000 1f200200 00000000
